//--- design/mips_pkg.sv
// Shared encodings for the five-stage MIPS subset core
// Opcodes, function codes, ALU operation codes and the two instruction views

package mips_pkg;

    typedef logic [4:0] reg_idx_t;

    // One instruction word, read as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [5:0] op;
            reg_idx_t   rs;
            reg_idx_t   rt;
            reg_idx_t   rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  op;
            reg_idx_t    rs;
            reg_idx_t    rt;
            logic [15:0] imm;
        } i;
    } mips_insn_t;

    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;
    localparam logic [5:0] op_beq   = 6'h04;

    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_jr   = 6'h08;

    localparam logic [2:0] alu_add = 3'd0;
    localparam logic [2:0] alu_sub = 3'd1;
    localparam logic [2:0] alu_and = 3'd2;
    localparam logic [2:0] alu_or  = 3'd3;
    localparam logic [2:0] alu_slt = 3'd4;

    // JR through this register ends the program
    localparam reg_idx_t link_reg = 5'd31;

endpackage

//--- design/insn_mem.sv
// Instruction memory
// Host loads words through a clocked write port, fetch reads combinationally

module insn_mem import mips_pkg::*; #(
    parameter int imem_addr_bits = 8
) (
    input  logic                      clock,
    input  logic                      load_we,
    input  logic [imem_addr_bits-1:0] load_addr,
    input  logic [31:0]               load_data,
    input  logic [imem_addr_bits-1:0] fetch_addr,
    output mips_insn_t                fetch_insn
);

    mips_insn_t words [2**imem_addr_bits];

    always_ff @(posedge clock) begin
        if (load_we) begin
            words[load_addr] <= load_data;
        end
    end

    assign fetch_insn = words[fetch_addr];

endmodule

//--- design/fetch_stage.sv
// Fetch stage
// Program counter with branch redirect and stall hold, plus the fetch/decode register

module fetch_stage import mips_pkg::*; #(
    parameter int imem_addr_bits = 8
) (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      start,
    input  logic                      stall,
    input  logic                      redirect,
    input  logic [31:0]               target,
    input  mips_insn_t                fetch_insn,
    output logic [imem_addr_bits-1:0] fetch_addr,
    output mips_insn_t                id_insn,
    output logic [31:0]               id_pc4,
    output logic                      id_valid
);

    logic [31:0] pc;
    logic [31:0] pc4;

    assign pc4        = pc + 32'd4;
    assign fetch_addr = pc[imem_addr_bits+1:2];

    // Idle core sits at zero and feeds bubbles
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= '0;
            id_valid <= 1'b0;
        end else if (!start) begin
            pc       <= '0;
            id_valid <= 1'b0;
        end else if (redirect) begin
            pc       <= target;
            id_valid <= 1'b0;
        end else if (!stall) begin
            pc       <= pc4;
            id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (start && !redirect && !stall) begin
            id_insn <= fetch_insn;
            id_pc4  <= pc4;
        end
    end

endmodule

//--- design/decode_stage.sv
// Decode stage
// Instruction decode, 32-entry register file with write-through from writeback,
// debug read port and the decode/execute register

module decode_stage import mips_pkg::*; (
    input  logic        clock,
    input  logic        arst_n,
    input  mips_insn_t  id_insn,
    input  logic [31:0] id_pc4,
    input  logic        id_valid,
    input  logic        stall,
    input  logic        redirect,
    input  logic        wb_we,
    input  reg_idx_t    wb_rd,
    input  logic [31:0] wb_data,
    input  reg_idx_t    dbg_reg,
    output reg_idx_t    rs_idx,
    output reg_idx_t    rt_idx,
    output logic        rs_used,
    output logic        rt_used,
    output logic        ex_valid,
    output logic [31:0] ex_rs_val,
    output logic [31:0] ex_rt_val,
    output logic [31:0] ex_imm,
    output logic [31:0] ex_pc4,
    output logic [2:0]  ex_alu_op,
    output logic        ex_use_imm,
    output reg_idx_t    ex_rd,
    output logic        ex_reg_we,
    output logic        ex_mem_read,
    output logic        ex_mem_write,
    output logic        ex_is_beq,
    output logic        ex_is_jr,
    output logic        ex_is_link_jr,
    output logic [31:0] dbg_data
);

    logic [31:0] regs [32];
    logic [5:0]  op;
    logic [5:0]  funct;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] imm_ext;
    reg_idx_t    dest;
    logic [2:0]  alu_op;
    logic        use_imm;
    logic        reg_we;
    logic        mem_read;
    logic        mem_write;
    logic        is_beq;
    logic        is_jr;
    logic        rs_use;
    logic        rt_use;
    logic        bubble;

    assign op     = id_insn.r.op;
    assign funct  = id_insn.r.funct;
    assign rs_idx = id_insn.i.rs;
    assign rt_idx = id_insn.i.rt;

    // ORI zero-extends, everything else sign-extends
    assign imm_ext = (op == op_ori) ? {16'b0, id_insn.i.imm}
                                    : {{16{id_insn.i.imm[15]}}, id_insn.i.imm};
    assign dest    = (op == op_rtype) ? id_insn.r.rd : id_insn.i.rt;

    always_comb begin
        alu_op    = alu_add;
        use_imm   = 1'b0;
        reg_we    = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_beq    = 1'b0;
        is_jr     = 1'b0;
        rs_use    = 1'b1;
        rt_use    = 1'b0;
        case (op)
            op_rtype: begin
                rt_use = (funct != fn_jr);
                case (funct)
                    fn_addu: reg_we = 1'b1;
                    fn_subu: begin
                        alu_op = alu_sub;
                        reg_we = 1'b1;
                    end
                    fn_and: begin
                        alu_op = alu_and;
                        reg_we = 1'b1;
                    end
                    fn_or: begin
                        alu_op = alu_or;
                        reg_we = 1'b1;
                    end
                    fn_slt: begin
                        alu_op = alu_slt;
                        reg_we = 1'b1;
                    end
                    fn_jr:   is_jr = 1'b1;
                    default: ;
                endcase
            end
            op_addiu: begin
                use_imm = 1'b1;
                reg_we  = 1'b1;
            end
            op_ori: begin
                alu_op  = alu_or;
                use_imm = 1'b1;
                reg_we  = 1'b1;
            end
            op_lw: begin
                use_imm  = 1'b1;
                reg_we   = 1'b1;
                mem_read = 1'b1;
            end
            op_sw: begin
                use_imm   = 1'b1;
                rt_use    = 1'b1;
                mem_write = 1'b1;
            end
            op_beq: begin
                alu_op = alu_sub;
                rt_use = 1'b1;
                is_beq = 1'b1;
            end
            default: rs_use = 1'b0;
        endcase
    end

    assign rs_used = id_valid && rs_use;
    assign rt_used = id_valid && rt_use;

    // Register zero is never written, so it reads zero from reset on
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Writeback in the same cycle is seen through the bypass
    assign rs_val = (rs_idx == '0) ? '0 :
                    (wb_we && wb_rd == rs_idx) ? wb_data : regs[rs_idx];
    assign rt_val = (rt_idx == '0) ? '0 :
                    (wb_we && wb_rd == rt_idx) ? wb_data : regs[rt_idx];

    assign dbg_data = regs[dbg_reg];

    assign bubble = !id_valid || stall || redirect;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid      <= 1'b0;
            ex_reg_we     <= 1'b0;
            ex_mem_read   <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_is_beq     <= 1'b0;
            ex_is_jr      <= 1'b0;
            ex_is_link_jr <= 1'b0;
        end else begin
            ex_valid      <= !bubble;
            ex_reg_we     <= !bubble && reg_we;
            ex_mem_read   <= !bubble && mem_read;
            ex_mem_write  <= !bubble && mem_write;
            ex_is_beq     <= !bubble && is_beq;
            ex_is_jr      <= !bubble && is_jr;
            ex_is_link_jr <= !bubble && is_jr && (rs_idx == link_reg);
        end
    end

    always_ff @(posedge clock) begin
        ex_rs_val  <= rs_val;
        ex_rt_val  <= rt_val;
        ex_imm     <= imm_ext;
        ex_pc4     <= id_pc4;
        ex_alu_op  <= alu_op;
        ex_use_imm <= use_imm;
        ex_rd      <= dest;
    end

endmodule

//--- design/hazard_unit.sv
// Hazard detection
// Stalls decode while a source register is still being produced in execute or memory

module hazard_unit import mips_pkg::*; (
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  logic     rs_used,
    input  logic     rt_used,
    input  reg_idx_t ex_rd,
    input  logic     ex_we,
    input  reg_idx_t mem_rd,
    input  logic     mem_we,
    output logic     stall
);

    logic rs_hit;
    logic rt_hit;

    // Writeback is covered by the register file bypass
    assign rs_hit = rs_used && (rs_idx != '0) &&
                    ((ex_we && rs_idx == ex_rd) || (mem_we && rs_idx == mem_rd));
    assign rt_hit = rt_used && (rt_idx != '0) &&
                    ((ex_we && rt_idx == ex_rd) || (mem_we && rt_idx == mem_rd));

    assign stall = rs_hit || rt_hit;

endmodule

//--- design/execute_stage.sv
// Execute stage
// ALU, branch and jump resolution, end-of-program detection
// and the execute/memory register

module execute_stage import mips_pkg::*; (
    input  logic        clock,
    input  logic        arst_n,
    input  logic        ex_valid,
    input  logic [31:0] ex_rs_val,
    input  logic [31:0] ex_rt_val,
    input  logic [31:0] ex_imm,
    input  logic [31:0] ex_pc4,
    input  logic [2:0]  ex_alu_op,
    input  logic        ex_use_imm,
    input  reg_idx_t    ex_rd,
    input  logic        ex_reg_we,
    input  logic        ex_mem_read,
    input  logic        ex_mem_write,
    input  logic        ex_is_beq,
    input  logic        ex_is_jr,
    input  logic        ex_is_link_jr,
    output logic        redirect,
    output logic [31:0] target,
    output logic        ex_we,
    output logic        mem_valid,
    output logic [31:0] mem_result,
    output logic [31:0] mem_store_val,
    output reg_idx_t    mem_rd,
    output logic        mem_we,
    output logic        mem_read,
    output logic        mem_write,
    output logic        program_done
);

    logic [31:0] opb;
    logic [31:0] alu_y;
    logic        beq_taken;

    assign opb = ex_use_imm ? ex_imm : ex_rt_val;

    always_comb begin
        case (ex_alu_op)
            alu_sub: alu_y = ex_rs_val - opb;
            alu_and: alu_y = ex_rs_val & opb;
            alu_or:  alu_y = ex_rs_val | opb;
            alu_slt: alu_y = {31'b0, $signed(ex_rs_val) < $signed(opb)};
            default: alu_y = ex_rs_val + opb;
        endcase
    end

    assign beq_taken = ex_valid && ex_is_beq && (ex_rs_val == ex_rt_val);
    assign redirect  = beq_taken || (ex_valid && ex_is_jr);
    assign target    = ex_is_jr ? ex_rs_val : ex_pc4 + {ex_imm[29:0], 2'b00};
    assign ex_we     = ex_valid && ex_reg_we;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mem_valid    <= 1'b0;
            mem_we       <= 1'b0;
            mem_read     <= 1'b0;
            mem_write    <= 1'b0;
            program_done <= 1'b0;
        end else begin
            mem_valid <= ex_valid;
            mem_we    <= ex_we;
            mem_read  <= ex_valid && ex_mem_read;
            mem_write <= ex_valid && ex_mem_write;
            // Sticky until reset
            if (ex_valid && ex_is_link_jr) begin
                program_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        mem_result    <= alu_y;
        mem_store_val <= ex_rt_val;
        mem_rd        <= ex_rd;
    end

endmodule

//--- design/mem_stage.sv
// Memory stage
// Word-addressed data memory and the memory/writeback register
// that drives the register file write port

module mem_stage import mips_pkg::*; #(
    parameter int dmem_addr_bits = 8
) (
    input  logic        clock,
    input  logic        arst_n,
    input  logic        mem_valid,
    input  logic [31:0] mem_result,
    input  logic [31:0] mem_store_val,
    input  reg_idx_t    mem_rd,
    input  logic        mem_we,
    input  logic        mem_read,
    input  logic        mem_write,
    output logic        wb_we,
    output reg_idx_t    wb_rd,
    output logic [31:0] wb_data
);

    logic [31:0]               dmem [2**dmem_addr_bits];
    logic [dmem_addr_bits-1:0] word_addr;

    assign word_addr = mem_result[dmem_addr_bits+1:2];

    // Every program starts with cleared data memory
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < 2**dmem_addr_bits; k++) begin
                dmem[k] <= '0;
            end
        end else if (mem_valid && mem_write) begin
            dmem[word_addr] <= mem_store_val;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= mem_valid && mem_we;
        end
    end

    always_ff @(posedge clock) begin
        wb_rd   <= mem_rd;
        wb_data <= mem_read ? dmem[word_addr] : mem_result;
    end

endmodule

//--- design/pipeline.sv
// Five-stage MIPS subset core
// Host loads the program while idle, start runs it until JR through r31

module pipeline import mips_pkg::*; #(
    parameter int imem_addr_bits = 8,
    parameter int dmem_addr_bits = 8
) (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      load_we,
    input  logic [imem_addr_bits-1:0] load_addr,
    input  logic [31:0]               load_data,
    input  logic                      start,
    input  reg_idx_t                  dbg_reg,
    output logic [31:0]               dbg_data,
    output logic                      program_done
);

    logic [imem_addr_bits-1:0] fetch_addr;
    mips_insn_t                fetch_insn;
    mips_insn_t                id_insn;
    logic [31:0]               id_pc4;
    logic                      id_valid;
    logic                      stall;
    logic                      redirect;
    logic [31:0]               target;
    reg_idx_t                  rs_idx;
    reg_idx_t                  rt_idx;
    logic                      rs_used;
    logic                      rt_used;
    logic                      ex_valid;
    logic [31:0]               ex_rs_val;
    logic [31:0]               ex_rt_val;
    logic [31:0]               ex_imm;
    logic [31:0]               ex_pc4;
    logic [2:0]                ex_alu_op;
    logic                      ex_use_imm;
    reg_idx_t                  ex_rd;
    logic                      ex_reg_we;
    logic                      ex_mem_read;
    logic                      ex_mem_write;
    logic                      ex_is_beq;
    logic                      ex_is_jr;
    logic                      ex_is_link_jr;
    logic                      ex_we;
    logic                      mem_valid;
    logic [31:0]               mem_result;
    logic [31:0]               mem_store_val;
    reg_idx_t                  mem_rd;
    logic                      mem_we;
    logic                      mem_read;
    logic                      mem_write;
    logic                      wb_we;
    reg_idx_t                  wb_rd;
    logic [31:0]               wb_data;

    // Loads only while idle
    insn_mem #(.imem_addr_bits(imem_addr_bits)) u_imem (
        .clock      (clock),
        .load_we    (load_we && !start),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .fetch_addr (fetch_addr),
        .fetch_insn (fetch_insn)
    );

    // Fetch stops once the program has ended
    fetch_stage #(.imem_addr_bits(imem_addr_bits)) u_fetch (
        .clock      (clock),
        .arst_n     (arst_n),
        .start      (start && !program_done),
        .stall      (stall),
        .redirect   (redirect),
        .target     (target),
        .fetch_insn (fetch_insn),
        .fetch_addr (fetch_addr),
        .id_insn    (id_insn),
        .id_pc4     (id_pc4),
        .id_valid   (id_valid)
    );

    decode_stage u_decode (
        .clock         (clock),
        .arst_n        (arst_n),
        .id_insn       (id_insn),
        .id_pc4        (id_pc4),
        .id_valid      (id_valid),
        .stall         (stall),
        .redirect      (redirect),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .dbg_reg       (dbg_reg),
        .rs_idx        (rs_idx),
        .rt_idx        (rt_idx),
        .rs_used       (rs_used),
        .rt_used       (rt_used),
        .ex_valid      (ex_valid),
        .ex_rs_val     (ex_rs_val),
        .ex_rt_val     (ex_rt_val),
        .ex_imm        (ex_imm),
        .ex_pc4        (ex_pc4),
        .ex_alu_op     (ex_alu_op),
        .ex_use_imm    (ex_use_imm),
        .ex_rd         (ex_rd),
        .ex_reg_we     (ex_reg_we),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .ex_is_beq     (ex_is_beq),
        .ex_is_jr      (ex_is_jr),
        .ex_is_link_jr (ex_is_link_jr),
        .dbg_data      (dbg_data)
    );

    hazard_unit u_hazard (
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .rs_used (rs_used),
        .rt_used (rt_used),
        .ex_rd   (ex_rd),
        .ex_we   (ex_we),
        .mem_rd  (mem_rd),
        .mem_we  (mem_we),
        .stall   (stall)
    );

    execute_stage u_execute (
        .clock         (clock),
        .arst_n        (arst_n),
        .ex_valid      (ex_valid),
        .ex_rs_val     (ex_rs_val),
        .ex_rt_val     (ex_rt_val),
        .ex_imm        (ex_imm),
        .ex_pc4        (ex_pc4),
        .ex_alu_op     (ex_alu_op),
        .ex_use_imm    (ex_use_imm),
        .ex_rd         (ex_rd),
        .ex_reg_we     (ex_reg_we),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .ex_is_beq     (ex_is_beq),
        .ex_is_jr      (ex_is_jr),
        .ex_is_link_jr (ex_is_link_jr),
        .redirect      (redirect),
        .target        (target),
        .ex_we         (ex_we),
        .mem_valid     (mem_valid),
        .mem_result    (mem_result),
        .mem_store_val (mem_store_val),
        .mem_rd        (mem_rd),
        .mem_we        (mem_we),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .program_done  (program_done)
    );

    mem_stage #(.dmem_addr_bits(dmem_addr_bits)) u_mem (
        .clock         (clock),
        .arst_n        (arst_n),
        .mem_valid     (mem_valid),
        .mem_result    (mem_result),
        .mem_store_val (mem_store_val),
        .mem_rd        (mem_rd),
        .mem_we        (mem_we),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

endmodule

//--- dv/pipeline_tb.sv
// Testbench for the five-stage MIPS subset core
// Loads short programs, runs each to JR through r31 and compares every
// register with a behavioural model of the instruction set

module pipeline_tb import mips_pkg::*; ();

    localparam int run_timeout = 2000;

    logic        clock;
    logic        arst_n;
    logic        load_we;
    logic [7:0]  load_addr;
    logic [31:0] load_data;
    logic        start;
    logic [4:0]  dbg_reg;
    logic [31:0] dbg_data;
    logic        program_done;

    logic [31:0] prog [$];
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [256];
    int          pass_count;
    int          fail_count;

    pipeline #(.imem_addr_bits(8), .dmem_addr_bits(8)) uut (
        .clock        (clock),
        .arst_n       (arst_n),
        .load_we      (load_we),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .start        (start),
        .dbg_reg      (dbg_reg),
        .dbg_data     (dbg_data),
        .program_done (program_done)
    );

    always #2 clock = ~clock;

    task automatic rtype(input logic [5:0] fn, input logic [4:0] rd,
                         input logic [4:0] rs, input logic [4:0] rt);
        prog.push_back({op_rtype, rs, rt, rd, 5'd0, fn});
    endtask

    task automatic itype(input logic [5:0] op, input logic [4:0] rt,
                         input logic [4:0] rs, input logic [15:0] imm);
        prog.push_back({op, rs, rt, imm});
    endtask

    // Program ends on JR through r31 and two NOP words follow
    task automatic end_with_jr();
        rtype(fn_jr, 5'd0, 5'd31, 5'd0);
        prog.push_back(32'h0);
        prog.push_back(32'h0);
    endtask

    // Sequential execution, no delay slot
    task automatic model_run();
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] addr;
        logic [31:0] y;
        logic [4:0]  rd;
        logic        wr;
        foreach (model_regs[k]) begin
            model_regs[k] = '0;
        end
        foreach (model_mem[k]) begin
            model_mem[k] = '0;
        end
        pc = '0;
        for (int steps = 0; steps < 1000; steps++) begin
            w    = (pc[31:2] < prog.size()) ? prog[pc[31:2]] : 32'h0;
            a    = model_regs[w[25:21]];
            b    = model_regs[w[20:16]];
            simm = {{16{w[15]}}, w[15:0]};
            addr = a + simm;
            y    = '0;
            rd   = w[20:16];
            wr   = 1'b1;
            pc   = pc + 32'd4;
            case (w[31:26])
                op_rtype: begin
                    rd = w[15:11];
                    case (w[5:0])
                        fn_addu: y = a + b;
                        fn_subu: y = a - b;
                        fn_and:  y = a & b;
                        fn_or:   y = a | b;
                        fn_slt:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                    if (w[5:0] == fn_jr) begin
                        if (w[25:21] == 5'd31) begin
                            break;
                        end
                        pc = a;
                    end
                end
                op_addiu: y = addr;
                op_ori:   y = a | {16'h0, w[15:0]};
                op_lw:    y = model_mem[addr[9:2]];
                op_sw: begin
                    model_mem[addr[9:2]] = b;
                    wr = 1'b0;
                end
                op_beq: begin
                    if (a == b) begin
                        pc = pc + (simm << 2);
                    end
                    wr = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            if (wr && rd != 5'd0) begin
                model_regs[rd] = y;
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clock);
        arst_n  <= 1'b0;
        start   <= 1'b0;
        load_we <= 1'b0;
        repeat (3) @(posedge clock);
        arst_n <= 1'b1;
    endtask

    task automatic run_program(input string name);
        int cycles;
        int errs;
        errs = 0;
        model_run();
        apply_reset();
        @(negedge clock);
        assert (program_done === 1'b0) else begin
            $display("%s: program_done is high right after reset", name);
            errs++;
        end
        foreach (prog[k]) begin
            @(posedge clock);
            load_we   <= 1'b1;
            load_addr <= 8'(k);
            load_data <= prog[k];
            @(negedge clock);
            assert (program_done === 1'b0) else begin
                $display("%s: program_done is high while loading", name);
                errs++;
            end
        end
        @(posedge clock);
        load_we <= 1'b0;
        @(posedge clock);
        start <= 1'b1;
        cycles = 0;
        while (program_done !== 1'b1 && cycles < run_timeout) begin
            @(negedge clock);
            cycles++;
        end
        if (program_done !== 1'b1) begin
            $display("%s: timeout, program_done never rose", name);
            errs++;
        end
        // Instructions older than the JR leave memory and writeback
        repeat (3) @(posedge clock);
        for (int r = 0; r < 32; r++) begin
            @(posedge clock);
            dbg_reg <= 5'(r);
            @(negedge clock);
            assert (dbg_data === model_regs[r]) else begin
                $display("Mismatch %s r%0d expected %h actual %h",
                         name, r, model_regs[r], dbg_data);
                errs++;
            end
        end
        assert (program_done === 1'b1) else begin
            $display("%s: program_done did not stay high", name);
            errs++;
        end
        if (errs == 0) begin
            pass_count++;
            $display("Test %s passed", name);
        end else begin
            fail_count++;
            $display("Test %s failed with %0d errors", name, errs);
        end
    endtask

    task automatic build_arith();
        logic [15:0] v1;
        logic [15:0] v2;
        logic [15:0] v3;
        v1 = 16'($urandom);
        v2 = 16'($urandom);
        // Negative once sign-extended
        v3 = 16'($urandom) | 16'h8000;
        prog.delete();
        itype(op_addiu, 5'd1, 5'd0, v1);
        itype(op_ori,   5'd2, 5'd0, v2);
        itype(op_addiu, 5'd3, 5'd0, v3);
        itype(op_ori,   5'd4, 5'd1, v2);
        rtype(fn_addu,  5'd5, 5'd1, 5'd2);
        rtype(fn_subu,  5'd6, 5'd3, 5'd2);
        rtype(fn_and,   5'd7, 5'd1, 5'd3);
        rtype(fn_or,    5'd8, 5'd2, 5'd3);
        rtype(fn_slt,   5'd9, 5'd3, 5'd2);
        rtype(fn_slt,   5'd10, 5'd2, 5'd3);
        rtype(fn_slt,   5'd11, 5'd1, 5'd5);
        end_with_jr();
    endtask

    task automatic build_chain();
        logic [15:0] v1;
        logic [15:0] v2;
        v1 = 16'($urandom);
        v2 = 16'($urandom);
        prog.delete();
        itype(op_addiu, 5'd1, 5'd0, v1);
        rtype(fn_addu,  5'd2, 5'd1, 5'd1);
        rtype(fn_subu,  5'd3, 5'd2, 5'd1);
        itype(op_ori,   5'd4, 5'd3, v2);
        rtype(fn_or,    5'd4, 5'd4, 5'd2);
        // Consumer two slots behind its producer
        itype(op_ori,   5'd5, 5'd0, v2);
        itype(op_addiu, 5'd6, 5'd0, v1);
        rtype(fn_addu,  5'd7, 5'd5, 5'd1);
        // Producer writes back as the consumer decodes
        itype(op_addiu, 5'd8, 5'd0, v2);
        prog.push_back(32'h0);
        prog.push_back(32'h0);
        rtype(fn_subu,  5'd9, 5'd8, 5'd6);
        end_with_jr();
    endtask

    task automatic build_memory();
        logic [15:0] v1;
        logic [15:0] v2;
        logic [15:0] v3;
        v1 = 16'($urandom);
        v2 = 16'($urandom);
        v3 = 16'($urandom) | 16'h8000;
        prog.delete();
        itype(op_ori,   5'd1, 5'd0, v1);
        itype(op_ori,   5'd2, 5'd0, v2);
        itype(op_addiu, 5'd3, 5'd0, v3);
        itype(op_addiu, 5'd20, 5'd0, 16'h0040);
        itype(op_sw,    5'd1, 5'd20, 16'h0000);
        itype(op_sw,    5'd2, 5'd20, 16'h0004);
        itype(op_sw,    5'd3, 5'd20, 16'hfffc);
        itype(op_lw,    5'd4, 5'd20, 16'h0000);
        itype(op_lw,    5'd5, 5'd20, 16'h0004);
        itype(op_lw,    5'd6, 5'd0, 16'h003c);
        rtype(fn_addu,  5'd7, 5'd6, 5'd4);
        itype(op_lw,    5'd8, 5'd20, 16'h0008);
        end_with_jr();
    endtask

    task automatic build_branch();
        logic [15:0] v1;
        v1 = 16'($urandom) & 16'h7fff;
        prog.delete();
        itype(op_ori, 5'd1, 5'd0, v1);
        itype(op_ori, 5'd2, 5'd0, v1);
        itype(op_ori, 5'd3, 5'd0, v1 + 16'd1);
        // Taken, skips r10 and r11
        itype(op_beq, 5'd2, 5'd1, 16'd2);
        itype(op_ori, 5'd10, 5'd0, 16'haaaa);
        itype(op_ori, 5'd11, 5'd0, 16'hbbbb);
        itype(op_ori, 5'd12, 5'd0, 16'hcccc);
        // Not taken
        itype(op_beq, 5'd3, 5'd1, 16'd1);
        itype(op_ori, 5'd13, 5'd0, 16'hdddd);
        itype(op_ori, 5'd14, 5'd0, 16'heeee);
        end_with_jr();
    endtask

    task automatic build_zero();
        logic [15:0] v1;
        logic [15:0] v2;
        v1 = 16'($urandom);
        v2 = 16'($urandom) | 16'h0001;
        prog.delete();
        itype(op_addiu, 5'd0, 5'd0, v1);
        itype(op_ori,   5'd1, 5'd0, v2);
        rtype(fn_addu,  5'd0, 5'd1, 5'd1);
        rtype(fn_addu,  5'd2, 5'd0, 5'd1);
        itype(op_ori,   5'd0, 5'd1, v1);
        rtype(fn_or,    5'd3, 5'd0, 5'd0);
        end_with_jr();
    endtask

    task automatic build_done();
        prog.delete();
        itype(op_addiu, 5'd1, 5'd0, 16'($urandom));
        end_with_jr();
    endtask

    initial begin
        clock      = 1'b0;
        arst_n     = 1'b0;
        load_we    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        start      = 1'b0;
        dbg_reg    = '0;
        pass_count = 0;
        fail_count = 0;
        void'($urandom(29356));

        build_arith();
        run_program("arith_logic");
        build_chain();
        run_program("dependence_chain");
        build_memory();
        run_program("memory");
        build_branch();
        run_program("control_flow");
        build_zero();
        run_program("register_zero");
        build_done();
        run_program("completion");

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- mips_lite.f
design/mips_pkg.sv
design/insn_mem.sv
design/fetch_stage.sv
design/decode_stage.sv
design/hazard_unit.sv
design/execute_stage.sv
design/mem_stage.sv
design/pipeline.sv
dv/pipeline_tb.sv

//--- Bender.yml
package:
  name: mips_lite

sources:
  - files:
      - design/mips_pkg.sv
      - design/insn_mem.sv
      - design/fetch_stage.sv
      - design/decode_stage.sv
      - design/hazard_unit.sv
      - design/execute_stage.sv
      - design/mem_stage.sv
      - design/pipeline.sv
  - target: test
    files:
      - dv/pipeline_tb.sv
